// ==== verilog/fir_pkg.sv ====
// Shared definitions for the 29-tap complex symmetric FIR filter
// Data widths, tap and lane counts, FSM codes and complex I/Q types
`default_nettype none

package fir_pkg;

  // Sample, coefficient and arithmetic widths
  localparam int SAMP_W      = 24;
  localparam int COEF_W      = 27;
  localparam int PRE_W       = 25;
  localparam int PROD_W      = 53;
  localparam int PSUM_W      = 56;
  localparam int OUT_W       = 32;
  localparam int FRAC_SHIFT  = 23;

  // Filter geometry
  localparam int NUM_TAPS    = 29;
  localparam int NUM_COEFS   = 15;
  localparam int COEF_ADDR_W = 4;
  localparam int NUM_LANES   = 5;
  localparam int NUM_PHASES  = 3;
  localparam int FIFO_DEPTH  = 4;

  // Scheduler FSM codes
  localparam logic [1:0] ST_WAIT = 2'd0;
  localparam logic [1:0] ST_PH0  = 2'd1;
  localparam logic [1:0] ST_PH1  = 2'd2;
  localparam logic [1:0] ST_PH2  = 2'd3;

  typedef struct packed {logic signed [SAMP_W-1:0] i; logic signed [SAMP_W-1:0] q;} samp_t;
  typedef struct packed {logic signed [COEF_W-1:0] i; logic signed [COEF_W-1:0] q;} coef_t;
  typedef struct packed {logic signed [PRE_W-1:0] i; logic signed [PRE_W-1:0] q;} pre_t;
  typedef struct packed {logic signed [PROD_W-1:0] i; logic signed [PROD_W-1:0] q;} prod_t;

endpackage

`default_nettype wire

// ==== verilog/tap_bus_if.sv ====
// Operand bus from the tap scheduler to the MAC datapath
// One phase per valid strobe, the sink always accepts
`default_nettype none
`timescale 1ns/10ps

interface tap_bus_if;

  logic           valid;
  // Near taps and their mirrored far taps
  fir_pkg::samp_t samp_a [fir_pkg::NUM_LANES];
  fir_pkg::samp_t samp_b [fir_pkg::NUM_LANES];
  fir_pkg::coef_t coef   [fir_pkg::NUM_LANES];
  // Phase markers
  logic           first;
  logic           last;

  modport source (output valid, samp_a, samp_b, coef, first, last);
  modport sink   (input valid, samp_a, samp_b, coef, first, last);

endinterface

`default_nettype wire

// ==== verilog/sample_fifo.sv ====
// Input sample FIFO
// Circular buffer of I/Q samples with registered full and empty flags
`default_nettype none
`timescale 1ns/10ps

module sample_fifo
(
  input  logic           clk,
  input  logic           RST,
  input  logic           push_i,
  input  fir_pkg::samp_t data_i,
  input  logic           pop_i,
  output fir_pkg::samp_t head_o,
  output logic           empty_o,
  output logic           full_o
);

  fir_pkg::samp_t mem [fir_pkg::FIFO_DEPTH];

  logic [$clog2(fir_pkg::FIFO_DEPTH)-1:0] wr_ptr;
  logic [$clog2(fir_pkg::FIFO_DEPTH)-1:0] rd_ptr;
  logic [$clog2(fir_pkg::FIFO_DEPTH)-1:0] wr_ptr_inc;
  logic [$clog2(fir_pkg::FIFO_DEPTH)-1:0] rd_ptr_inc;
  logic                                   wr_en;
  logic                                   rd_en;

  // Pushes while full are lost
  assign wr_en      = push_i & ~full_o;
  assign rd_en      = pop_i & ~empty_o;
  assign wr_ptr_inc = wr_ptr + 1'b1;
  assign rd_ptr_inc = rd_ptr + 1'b1;
  assign head_o     = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      empty_o <= 1'b1;
      full_o  <= 1'b0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr_inc;
      if (rd_en)
        rd_ptr <= rd_ptr_inc;
      // Push and pop together keep both flags
      if (wr_en && !rd_en)
      begin
        empty_o <= 1'b0;
        full_o  <= (wr_ptr_inc == rd_ptr);
      end
      else if (rd_en && !wr_en)
      begin
        full_o  <= 1'b0;
        empty_o <= (rd_ptr_inc == wr_ptr);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fir_scheduler.sv ====
// Tap scheduler for the symmetric complex FIR
// Holds coefficients and the delay line, pops one sample per output
// and issues three phases of mirrored tap pairs onto the operand bus
`default_nettype none
`timescale 1ns/10ps

module fir_scheduler
(
  input  logic                            clk,
  input  logic                            RST,
  input  fir_pkg::samp_t                  head_i,
  input  logic                            empty_i,
  output logic                            pop_o,
  input  logic                            push_coef_i,
  input  logic [fir_pkg::COEF_ADDR_W-1:0] coef_addr_i,
  input  fir_pkg::coef_t                  coef_i,
  tap_bus_if.source                       bus
);

  fir_pkg::coef_t coef_mem [fir_pkg::NUM_COEFS];
  fir_pkg::samp_t dly      [fir_pkg::NUM_TAPS];
  logic [1:0]     state;

  // Pop only from the idle state
  assign pop_o = (state == fir_pkg::ST_WAIT) & ~empty_i;

  //////////////////////////////////////////////////////////////////////
  // Coefficient memory and delay line
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      for (int c = 0; c < fir_pkg::NUM_COEFS; c++)
        coef_mem[c] <= '0;
    end
    else if (push_coef_i && (int'(coef_addr_i) < fir_pkg::NUM_COEFS))
      coef_mem[coef_addr_i] <= coef_i;
  end

  // Newest sample lands in tap 0
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      for (int t = 0; t < fir_pkg::NUM_TAPS; t++)
        dly[t] <= '0;
    end
    else if (pop_o)
    begin
      dly[0] <= head_i;
      for (int t = 1; t < fir_pkg::NUM_TAPS; t++)
        dly[t] <= dly[t-1];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Phase FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      state     <= fir_pkg::ST_WAIT;
      bus.valid <= 1'b0;
      bus.first <= 1'b0;
      bus.last  <= 1'b0;
    end
    else
    begin
      case (state)
        fir_pkg::ST_WAIT: if (!empty_i) state <= fir_pkg::ST_PH0;
        fir_pkg::ST_PH0:  state <= fir_pkg::ST_PH1;
        fir_pkg::ST_PH1:  state <= fir_pkg::ST_PH2;
        default:          state <= fir_pkg::ST_WAIT;
      endcase
      bus.valid <= (state != fir_pkg::ST_WAIT);
      bus.first <= (state == fir_pkg::ST_PH0);
      bus.last  <= (state == fir_pkg::ST_PH2);
    end
  end

  // Lane l of phase p pairs tap 5p+l with tap 28-(5p+l)
  always_ff @(posedge clk)
  begin
    for (int l = 0; l < fir_pkg::NUM_LANES; l++)
    begin
      case (state)
        fir_pkg::ST_PH0:
        begin
          bus.samp_a[l] <= dly[l];
          bus.samp_b[l] <= dly[fir_pkg::NUM_TAPS-1-l];
          bus.coef[l]   <= coef_mem[l];
        end
        fir_pkg::ST_PH1:
        begin
          bus.samp_a[l] <= dly[fir_pkg::NUM_LANES+l];
          bus.samp_b[l] <= dly[fir_pkg::NUM_TAPS-1-fir_pkg::NUM_LANES-l];
          bus.coef[l]   <= coef_mem[fir_pkg::NUM_LANES+l];
        end
        fir_pkg::ST_PH2:
        begin
          bus.samp_a[l] <= dly[(fir_pkg::NUM_PHASES-1)*fir_pkg::NUM_LANES+l];
          // Center tap has no mirror partner
          if ((fir_pkg::NUM_PHASES-1)*fir_pkg::NUM_LANES + l == fir_pkg::NUM_TAPS/2)
            bus.samp_b[l] <= '0;
          else
            bus.samp_b[l] <= dly[fir_pkg::NUM_TAPS-1-(fir_pkg::NUM_PHASES-1)*fir_pkg::NUM_LANES-l];
          bus.coef[l]   <= coef_mem[(fir_pkg::NUM_PHASES-1)*fir_pkg::NUM_LANES+l];
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/complex_mac_lane.sv ====
// One complex MAC lane
// Pre-adds a mirrored sample pair, then multiplies by a complex coefficient
`default_nettype none
`timescale 1ns/10ps

module complex_mac_lane
(
  input  logic           clk,
  input  logic           RST,
  input  fir_pkg::samp_t samp_a_i,
  input  fir_pkg::samp_t samp_b_i,
  input  fir_pkg::coef_t coef_i,
  output fir_pkg::prod_t prod_o
);

  fir_pkg::pre_t  pre_r;
  fir_pkg::coef_t coef_r;

  // Stage 1, pre-add with one guard bit
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      pre_r  <= '0;
      coef_r <= '0;
    end
    else
    begin
      pre_r.i <= fir_pkg::PRE_W'(samp_a_i.i) + fir_pkg::PRE_W'(samp_b_i.i);
      pre_r.q <= fir_pkg::PRE_W'(samp_a_i.q) + fir_pkg::PRE_W'(samp_b_i.q);
      coef_r  <= coef_i;
    end
  end

  // Stage 2, (A + jB)(C + jD) = (AC - BD) + j(BC + AD)
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
      prod_o <= '0;
    else
    begin
      prod_o.i <= fir_pkg::PROD_W'(pre_r.i) * fir_pkg::PROD_W'(coef_r.i)
                - fir_pkg::PROD_W'(pre_r.q) * fir_pkg::PROD_W'(coef_r.q);
      prod_o.q <= fir_pkg::PROD_W'(pre_r.q) * fir_pkg::PROD_W'(coef_r.i)
                + fir_pkg::PROD_W'(pre_r.i) * fir_pkg::PROD_W'(coef_r.q);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tap_datapath.sv ====
// Phase datapath of the FIR
// Five MAC lanes, a registered lane sum with fractional shift,
// and phase flags delayed to match the arithmetic
`default_nettype none
`timescale 1ns/10ps

module tap_datapath
(
  input  logic                             clk,
  input  logic                             RST,
  tap_bus_if.sink                          bus,
  output logic                             phase_valid_o,
  output logic                             first_o,
  output logic                             last_o,
  output logic signed [fir_pkg::OUT_W-1:0] phase_i_o,
  output logic signed [fir_pkg::OUT_W-1:0] phase_q_o
);

  fir_pkg::prod_t                   prod [fir_pkg::NUM_LANES];
  logic signed [fir_pkg::PSUM_W-1:0] sum_i;
  logic signed [fir_pkg::PSUM_W-1:0] sum_q;
  logic [1:0]                       valid_d;
  logic [1:0]                       first_d;
  logic [1:0]                       last_d;

  for (genvar g = 0; g < fir_pkg::NUM_LANES; g++)
  begin : g_lane
    complex_mac_lane u_lane
    (
      .clk      (clk),
      .RST      (RST),
      .samp_a_i (bus.samp_a[g]),
      .samp_b_i (bus.samp_b[g]),
      .coef_i   (bus.coef[g]),
      .prod_o   (prod[g])
    );
  end

  always_comb
  begin
    sum_i = '0;
    sum_q = '0;
    for (int l = 0; l < fir_pkg::NUM_LANES; l++)
    begin
      sum_i = sum_i + fir_pkg::PSUM_W'(prod[l].i);
      sum_q = sum_q + fir_pkg::PSUM_W'(prod[l].q);
    end
  end

  // Flags ride two stages beside the lanes, then the sum stage
  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      valid_d       <= '0;
      first_d       <= '0;
      last_d        <= '0;
      phase_valid_o <= 1'b0;
      first_o       <= 1'b0;
      last_o        <= 1'b0;
    end
    else
    begin
      valid_d       <= {valid_d[0], bus.valid};
      first_d       <= {first_d[0], bus.first};
      last_d        <= {last_d[0], bus.last};
      phase_valid_o <= valid_d[1];
      first_o       <= first_d[1];
      last_o        <= last_d[1];
    end
  end

  // Arithmetic shift then truncate, taken as one bit slice
  always_ff @(posedge clk)
  begin
    phase_i_o <= sum_i[fir_pkg::FRAC_SHIFT +: fir_pkg::OUT_W];
    phase_q_o <= sum_q[fir_pkg::FRAC_SHIFT +: fir_pkg::OUT_W];
  end

endmodule

`default_nettype wire

// ==== verilog/phase_accumulator.sv ====
// Phase accumulator
// Sums three phase results into one I/Q output and strobes push_o
`default_nettype none
`timescale 1ns/10ps

module phase_accumulator
(
  input  logic                             clk,
  input  logic                             RST,
  input  logic                             phase_valid_i,
  input  logic                             first_i,
  input  logic                             last_i,
  input  logic signed [fir_pkg::OUT_W-1:0] phase_i_i,
  input  logic signed [fir_pkg::OUT_W-1:0] phase_q_i,
  output logic                             push_o,
  output logic [fir_pkg::OUT_W-1:0]        fi_o,
  output logic [fir_pkg::OUT_W-1:0]        fq_o
);

  logic signed [fir_pkg::OUT_W-1:0] acc_i;
  logic signed [fir_pkg::OUT_W-1:0] acc_q;
  logic signed [fir_pkg::OUT_W-1:0] tot_i;
  logic signed [fir_pkg::OUT_W-1:0] tot_q;

  // Phase 0 restarts the total, wraps modulo 2^32
  assign tot_i = first_i ? phase_i_i : acc_i + phase_i_i;
  assign tot_q = first_i ? phase_q_i : acc_q + phase_q_i;

  always_ff @(posedge clk)
  begin
    if (phase_valid_i)
    begin
      acc_i <= tot_i;
      acc_q <= tot_q;
    end
  end

  always_ff @(posedge clk or posedge RST)
  begin
    if (RST)
    begin
      push_o <= 1'b0;
      fi_o   <= '0;
      fq_o   <= '0;
    end
    else
    begin
      push_o <= phase_valid_i & last_i;
      if (phase_valid_i && last_i)
      begin
        fi_o <= tot_i;
        fq_o <= tot_q;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/firc_top.sv ====
// Top level of the 29-tap complex symmetric FIR filter
// Input FIFO, tap scheduler, MAC datapath and phase accumulator
`default_nettype none
`timescale 1ns/10ps

module firc_top
(
  input  logic                              clk,
  input  logic                              RST,
  input  logic                              push_i,
  input  logic signed [fir_pkg::SAMP_W-1:0] samp_i_i,
  input  logic signed [fir_pkg::SAMP_W-1:0] samp_q_i,
  output logic                              stop_o,
  input  logic                              push_coef_i,
  input  logic [fir_pkg::COEF_ADDR_W-1:0]   coef_addr_i,
  input  logic signed [fir_pkg::COEF_W-1:0] coef_i_i,
  input  logic signed [fir_pkg::COEF_W-1:0] coef_q_i,
  output logic                              push_o,
  output logic [fir_pkg::OUT_W-1:0]         fi_o,
  output logic [fir_pkg::OUT_W-1:0]         fq_o
);

  fir_pkg::samp_t                   samp_in;
  fir_pkg::coef_t                   coef_in;
  fir_pkg::samp_t                   head;
  logic                             empty;
  logic                             pop;
  logic                             phase_valid;
  logic                             first;
  logic                             last;
  logic signed [fir_pkg::OUT_W-1:0] phase_i;
  logic signed [fir_pkg::OUT_W-1:0] phase_q;

  assign samp_in = '{i: samp_i_i, q: samp_q_i};
  assign coef_in = '{i: coef_i_i, q: coef_q_i};

  tap_bus_if tap_bus ();

  sample_fifo u_fifo
  (
    .clk (clk), .RST (RST), .push_i (push_i), .data_i (samp_in), .pop_i (pop),
    .head_o (head), .empty_o (empty), .full_o (stop_o)
  );

  fir_scheduler u_sched
  (
    .clk (clk), .RST (RST), .head_i (head), .empty_i (empty), .pop_o (pop),
    .push_coef_i (push_coef_i), .coef_addr_i (coef_addr_i), .coef_i (coef_in),
    .bus (tap_bus.source)
  );

  tap_datapath u_dpath
  (
    .clk (clk), .RST (RST), .bus (tap_bus.sink), .phase_valid_o (phase_valid),
    .first_o (first), .last_o (last), .phase_i_o (phase_i), .phase_q_o (phase_q)
  );

  phase_accumulator u_acc
  (
    .clk (clk), .RST (RST), .phase_valid_i (phase_valid), .first_i (first),
    .last_i (last), .phase_i_i (phase_i), .phase_q_i (phase_q),
    .push_o (push_o), .fi_o (fi_o), .fq_o (fq_o)
  );

endmodule

`default_nettype wire

// ==== dv/tb_firc.sv ====
// Testbench for the 29-tap complex symmetric FIR filter
// Directed tests checked against a reference model of the filter rule
`default_nettype none
`timescale 1ns/10ps

module tb_firc;

  localparam int TOTAL_SAMPLES  = 30 + 40 + 24 + 30;
  localparam int TIMEOUT_CYCLES = 4 * TOTAL_SAMPLES + 200;

  logic                              clk;
  logic                              RST;
  logic                              push_i;
  logic signed [fir_pkg::SAMP_W-1:0] samp_i_i;
  logic signed [fir_pkg::SAMP_W-1:0] samp_q_i;
  logic                              stop_o;
  logic                              push_coef_i;
  logic [fir_pkg::COEF_ADDR_W-1:0]   coef_addr_i;
  logic signed [fir_pkg::COEF_W-1:0] coef_i_i;
  logic signed [fir_pkg::COEF_W-1:0] coef_q_i;
  logic                              push_o;
  logic [fir_pkg::OUT_W-1:0]         fi_o;
  logic [fir_pkg::OUT_W-1:0]         fq_o;

  // Reference model state
  longint      ref_coef_i [fir_pkg::NUM_COEFS];
  longint      ref_coef_q [fir_pkg::NUM_COEFS];
  longint      ref_tap_i  [fir_pkg::NUM_TAPS];
  longint      ref_tap_q  [fir_pkg::NUM_TAPS];
  logic [31:0] exp_i [$];
  logic [31:0] exp_q [$];
  logic [31:0] mon_i;
  logic [31:0] mon_q;

  string       test_name;
  int          seed;
  int          error_count;
  int          check_count;
  int          test_count;
  int          out_count;
  int          accept_count;
  int          cycle_count;

  firc_top dut
  (
    .clk (clk), .RST (RST), .push_i (push_i), .samp_i_i (samp_i_i), .samp_q_i (samp_q_i),
    .stop_o (stop_o), .push_coef_i (push_coef_i), .coef_addr_i (coef_addr_i),
    .coef_i_i (coef_i_i), .coef_q_i (coef_q_i), .push_o (push_o), .fi_o (fi_o), .fq_o (fq_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model and checking helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected)
    begin
      $display("CHECK FAILED test %s %s expected %h actual %h", test_name, what,
               expected, actual);
      error_count++;
    end
  endtask

  // Shift in the driven sample, then sum c[min(k,28-k)] * x[k] per phase
  task automatic model_accept();
    longint      psum_i;
    longint      psum_q;
    longint      ph_i;
    longint      ph_q;
    logic [31:0] out_i;
    logic [31:0] out_q;
    int          m;
    for (int k = fir_pkg::NUM_TAPS - 1; k > 0; k--)
    begin
      ref_tap_i[k] = ref_tap_i[k-1];
      ref_tap_q[k] = ref_tap_q[k-1];
    end
    ref_tap_i[0] = longint'(samp_i_i);
    ref_tap_q[0] = longint'(samp_q_i);
    out_i = '0;
    out_q = '0;
    for (int p = 0; p < fir_pkg::NUM_PHASES; p++)
    begin
      psum_i = 0;
      psum_q = 0;
      for (int k = 0; k < fir_pkg::NUM_TAPS; k++)
      begin
        m = (k < fir_pkg::NUM_TAPS - 1 - k) ? k : fir_pkg::NUM_TAPS - 1 - k;
        if (m / fir_pkg::NUM_LANES == p)
        begin
          psum_i += ref_tap_i[k] * ref_coef_i[m] - ref_tap_q[k] * ref_coef_q[m];
          psum_q += ref_tap_i[k] * ref_coef_q[m] + ref_tap_q[k] * ref_coef_i[m];
        end
      end
      ph_i  = psum_i >>> fir_pkg::FRAC_SHIFT;
      ph_q  = psum_q >>> fir_pkg::FRAC_SHIFT;
      out_i = out_i + ph_i[31:0];
      out_q = out_q + ph_q[31:0];
    end
    exp_i.push_back(out_i);
    exp_q.push_back(out_q);
    accept_count++;
  endtask

  task automatic load_coef(input int addr, input int ci, input int cq);
    push_coef_i = 1'b1;
    coef_addr_i = addr[fir_pkg::COEF_ADDR_W-1:0];
    coef_i_i    = ci[fir_pkg::COEF_W-1:0];
    coef_q_i    = cq[fir_pkg::COEF_W-1:0];
    if (addr < fir_pkg::NUM_COEFS)
    begin
      ref_coef_i[addr] = longint'(coef_i_i);
      ref_coef_q[addr] = longint'(coef_q_i);
    end
    @(negedge clk);
    push_coef_i = 1'b0;
  endtask

  // stop_o is stable here and decides acceptance at the next rising edge
  task automatic push_sample(input int si, input int sq, input bit wait_ready,
                             output bit accepted);
    if (wait_ready)
    begin
      while (stop_o)
      begin
        push_i = 1'b0;
        @(negedge clk);
      end
    end
    push_i   = 1'b1;
    samp_i_i = si[fir_pkg::SAMP_W-1:0];
    samp_q_i = sq[fir_pkg::SAMP_W-1:0];
    accepted = !stop_o;
    if (accepted)
      model_accept();
    @(negedge clk);
  endtask

  task automatic wait_drain();
    push_i = 1'b0;
    while (exp_i.size() != 0)
      @(negedge clk);
    repeat (8) @(negedge clk);
  endtask

  task automatic report_test(input int err0, input int out0, input int acc0);
    if (out_count - out0 != accept_count - acc0)
    begin
      $display("Test %s produced %0d outputs for %0d accepted samples", test_name,
               out_count - out0, accept_count - acc0);
      error_count++;
    end
    test_count++;
    $display("Test %s finished with %0d errors", test_name, error_count - err0);
  endtask

  // Compare each push_o with the head of the model queue
  always @(negedge clk)
  begin
    if (!RST && push_o)
    begin
      out_count++;
      if (exp_i.size() == 0)
      begin
        $display("Unexpected push_o with no sample pending in test %s", test_name);
        error_count++;
      end
      else
      begin
        mon_i = exp_i.pop_front();
        mon_q = exp_q.pop_front();
        check_value("fi_o", mon_i, fi_o);
        check_value("fq_o", mon_q, fq_o);
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout expired after %0d cycles in test %s", cycle_count, test_name);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    int err0;
    int out0;
    int acc0;
    test_name = "reset_state";
    err0      = error_count;
    out0      = out_count;
    acc0      = accept_count;
    check_value("push_o", 32'd0, 32'(push_o));
    check_value("stop_o", 32'd0, 32'(stop_o));
    check_value("fi_o", 32'd0, fi_o);
    check_value("fq_o", 32'd0, fq_o);
    // Monitor flags any push here since nothing is pending
    repeat (20) @(negedge clk);
    report_test(err0, out0, acc0);
  endtask

  task automatic test_impulse();
    int err0;
    int out0;
    int acc0;
    bit acc;
    test_name = "impulse";
    err0      = error_count;
    out0      = out_count;
    acc0      = accept_count;
    for (int n = 0; n < fir_pkg::NUM_COEFS; n++)
      load_coef(n, (n + 1) * 150000 - 40000, 90000 - n * 13000);
    push_sample(4194303, -2097152, 1'b1, acc);
    repeat (fir_pkg::NUM_TAPS) push_sample(0, 0, 1'b1, acc);
    wait_drain();
    report_test(err0, out0, acc0);
  endtask

  task automatic test_random_data();
    int err0;
    int out0;
    int acc0;
    int ra;
    int rb;
    bit acc;
    test_name = "random_data";
    err0      = error_count;
    out0      = out_count;
    acc0      = accept_count;
    for (int n = 0; n < fir_pkg::NUM_COEFS; n++)
    begin
      ra = $random(seed);
      rb = $random(seed);
      load_coef(n, ra, rb);
    end
    repeat (40)
    begin
      ra = $random(seed);
      rb = $random(seed);
      push_sample(ra, rb, 1'b1, acc);
    end
    wait_drain();
    report_test(err0, out0, acc0);
  endtask

  task automatic test_back_pressure();
    int err0;
    int out0;
    int acc0;
    int ra;
    int rb;
    int dropped;
    bit stop_seen;
    bit acc;
    test_name = "back_pressure";
    err0      = error_count;
    out0      = out_count;
    acc0      = accept_count;
    dropped   = 0;
    stop_seen = 1'b0;
    repeat (24)
    begin
      if (stop_o)
        stop_seen = 1'b1;
      ra = $random(seed);
      rb = $random(seed);
      push_sample(ra, rb, 1'b0, acc);
      if (!acc)
        dropped++;
    end
    wait_drain();
    if (!stop_seen)
    begin
      $display("stop_o never rose while pushing every cycle in test %s", test_name);
      error_count++;
    end
    if (dropped == 0)
    begin
      $display("No push was dropped while the FIFO was full in test %s", test_name);
      error_count++;
    end
    report_test(err0, out0, acc0);
  endtask

  task automatic test_coef_reload();
    int err0;
    int out0;
    int acc0;
    bit acc;
    test_name = "coef_reload";
    err0      = error_count;
    out0      = out_count;
    acc0      = accept_count;
    for (int n = 0; n < fir_pkg::NUM_COEFS; n++)
      load_coef(n, -(n + 3) * 97000, n * n * 21000 - 500000);
    // Address 15 is out of range and leaves the model unchanged
    load_coef(15, -1, 12345678);
    push_sample(1048576, 3145728, 1'b1, acc);
    repeat (fir_pkg::NUM_TAPS) push_sample(0, 0, 1'b1, acc);
    wait_drain();
    report_test(err0, out0, acc0);
  endtask

  initial
  begin
    RST          = 1'b1;
    push_i       = 1'b0;
    samp_i_i     = '0;
    samp_q_i     = '0;
    push_coef_i  = 1'b0;
    coef_addr_i  = '0;
    coef_i_i     = '0;
    coef_q_i     = '0;
    seed         = 28;
    error_count  = 0;
    check_count  = 0;
    test_count   = 0;
    out_count    = 0;
    accept_count = 0;
    cycle_count  = 0;
    test_name    = "reset";
    for (int c = 0; c < fir_pkg::NUM_COEFS; c++)
    begin
      ref_coef_i[c] = 0;
      ref_coef_q[c] = 0;
    end
    for (int t = 0; t < fir_pkg::NUM_TAPS; t++)
    begin
      ref_tap_i[t] = 0;
      ref_tap_q[t] = 0;
    end
    repeat (10) @(negedge clk);
    RST = 1'b0;

    test_reset_state();
    test_impulse();
    test_random_data();
    test_back_pressure();
    test_coef_reload();

    $display("Summary: %0d tests, %0d checks, %0d outputs, %0d errors", test_count,
             check_count, out_count, error_count);
    if (error_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/fir_pkg.sv
verilog/tap_bus_if.sv
verilog/sample_fifo.sv
verilog/fir_scheduler.sv
verilog/complex_mac_lane.sv
verilog/tap_datapath.sv
verilog/phase_accumulator.sv
verilog/firc_top.sv
dv/tb_firc.sv

// ==== Makefile ====
# Verilator flow for the complex FIR filter

VERILATOR ?= verilator
TOP       ?= tb_firc
RTL_TOP   ?= firc_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Simulation passed" $(LOG) || { echo "FAIL: no result in $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
